// ==== all.f ====
+incdir+sim
rtl/core_pkg.sv
rtl/instr_mem.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mini_core.sv
sim/tb_mini_core.sv

// ==== rtl/core_pkg.sv ====
package core_pkg;

  localparam int xlen = 32;

  // major opcodes of the supported formats
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 codes
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_slt     = 3'b010;

  // funct7 codes, sub is the only one that differs from zero
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  localparam logic [31:0] ecall_word = 32'h0000_0073;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  // one instruction word, three views of it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
  } instr_t;

endpackage

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      hold,
  input  core_pkg::instr_t          if_instr,
  input  logic [core_pkg::xlen-1:0] if_pc,
  input  logic                      if_valid,
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] rs2_data,
  input  logic                      fwd_we,
  input  logic [4:0]                fwd_rd,
  input  logic [core_pkg::xlen-1:0] fwd_data,
  output logic [core_pkg::xlen-1:0] dec_pc,
  output logic                      ex_valid,
  output core_pkg::alu_op_t         ex_alu_op,
  output logic [core_pkg::xlen-1:0] ex_a,
  output logic [core_pkg::xlen-1:0] ex_b,
  output logic [4:0]                ex_rd,
  output logic                      ex_regwrite,
  output logic                      ex_ecall
);

  logic                      supported;
  logic                      is_ecall;
  logic                      use_imm;
  core_pkg::alu_op_t         alu_op;
  logic [core_pkg::xlen-1:0] imm;
  logic [4:0]                rd;
  logic [core_pkg::xlen-1:0] op_a;
  logic [core_pkg::xlen-1:0] fwd_b;
  logic [core_pkg::xlen-1:0] op_b;

  assign dec_pc = if_pc;

  ////////////////////
  // instruction decode
  ////////////////////

  always_comb begin
    supported = 1'b0;
    is_ecall  = 1'b0;
    use_imm   = 1'b0;
    alu_op    = core_pkg::alu_add;
    imm       = '0;
    rd        = '0;
    rs1       = '0;
    rs2       = '0;
    // opcode sits in the same bits in every view
    case (if_instr.r_fmt.opcode)
      core_pkg::op_reg: begin
        rs1       = if_instr.r_fmt.rs1;
        rs2       = if_instr.r_fmt.rs2;
        rd        = if_instr.r_fmt.rd;
        supported = 1'b1;
        case ({if_instr.r_fmt.funct7, if_instr.r_fmt.funct3})
          {core_pkg::f7_base, core_pkg::f3_add_sub}: alu_op = core_pkg::alu_add;
          {core_pkg::f7_sub, core_pkg::f3_add_sub}:  alu_op = core_pkg::alu_sub;
          {core_pkg::f7_base, core_pkg::f3_and}:     alu_op = core_pkg::alu_and;
          {core_pkg::f7_base, core_pkg::f3_or}:      alu_op = core_pkg::alu_or;
          {core_pkg::f7_base, core_pkg::f3_xor}:     alu_op = core_pkg::alu_xor;
          {core_pkg::f7_base, core_pkg::f3_slt}:     alu_op = core_pkg::alu_slt;
          default:                                   supported = 1'b0;
        endcase
      end
      core_pkg::op_imm: begin
        rs1       = if_instr.i_fmt.rs1;
        rd        = if_instr.i_fmt.rd;
        use_imm   = 1'b1;
        supported = 1'b1;
        imm       = {{20{if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.imm};
        case (if_instr.i_fmt.funct3)
          core_pkg::f3_add_sub: alu_op = core_pkg::alu_add;
          core_pkg::f3_and:     alu_op = core_pkg::alu_and;
          core_pkg::f3_or:      alu_op = core_pkg::alu_or;
          core_pkg::f3_xor:     alu_op = core_pkg::alu_xor;
          default:              supported = 1'b0;
        endcase
      end
      core_pkg::op_lui: begin
        rd        = if_instr.u_fmt.rd;
        use_imm   = 1'b1;
        supported = 1'b1;
        imm       = {if_instr.u_fmt.imm, 12'b0};
        alu_op    = core_pkg::alu_pass_b;
      end
      core_pkg::op_system: begin
        // only the exact ecall word, everything else retires as a no-op
        if (if_instr == core_pkg::ecall_word) begin
          supported = 1'b1;
          is_ecall  = 1'b1;
        end
      end
      default: begin
        supported = 1'b0;
      end
    endcase
  end

  ////////////////////
  // operand forwarding
  ////////////////////

  // result of the instruction in execute beats the register file
  assign op_a = (fwd_we && fwd_rd != 5'd0 && fwd_rd == rs1) ? fwd_data : rs1_data;
  assign fwd_b = (fwd_we && fwd_rd != 5'd0 && fwd_rd == rs2) ? fwd_data : rs2_data;
  assign op_b = use_imm ? imm : fwd_b;

  // decode-to-execute register, unsupported words become bubbles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid    <= 1'b0;
      ex_regwrite <= 1'b0;
      ex_ecall    <= 1'b0;
    end else if (!hold) begin
      ex_valid    <= if_valid && supported;
      ex_regwrite <= supported && !is_ecall;
      ex_ecall    <= is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      ex_alu_op <= alu_op;
      ex_a      <= op_a;
      ex_b      <= op_b;
      ex_rd     <= rd;
    end
  end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      hold,
  input  logic                      ex_valid,
  input  core_pkg::alu_op_t         ex_alu_op,
  input  logic [core_pkg::xlen-1:0] ex_a,
  input  logic [core_pkg::xlen-1:0] ex_b,
  input  logic [4:0]                ex_rd,
  input  logic                      ex_regwrite,
  input  logic                      ex_ecall,
  output logic                      wb_we,
  output logic [4:0]                wb_rd,
  output logic [core_pkg::xlen-1:0] wb_data,
  output logic                      halted
);

  logic [core_pkg::xlen-1:0] alu_res;
  logic                      less;

  ////////////////////
  // alu
  ////////////////////

  // slt compares signed
  assign less = $signed(ex_a) < $signed(ex_b);

  always_comb begin
    case (ex_alu_op)
      core_pkg::alu_add:    alu_res = ex_a + ex_b;
      core_pkg::alu_sub:    alu_res = ex_a - ex_b;
      core_pkg::alu_and:    alu_res = ex_a & ex_b;
      core_pkg::alu_or:     alu_res = ex_a | ex_b;
      core_pkg::alu_xor:    alu_res = ex_a ^ ex_b;
      core_pkg::alu_slt:    alu_res = {{(core_pkg::xlen - 1){1'b0}}, less};
      core_pkg::alu_pass_b: alu_res = ex_b;
      default:              alu_res = '0;
    endcase
  end

  ////////////////////
  // writeback
  ////////////////////

  // same value goes to the register file and back to decode
  assign wb_we   = ex_valid && ex_regwrite && !hold;
  assign wb_rd   = ex_rd;
  assign wb_data = alu_res;

  // sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (ex_valid && ex_ecall) begin
      halted <= 1'b1;
    end
  end

  halted_sticky: assert property (
    @(posedge clk) halted && rst_n |=> halted
  );

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
  parameter int imem_depth = 64,
  localparam int aw = $clog2(imem_depth)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      hold,
  output logic [aw-1:0]             imem_addr,
  input  logic [core_pkg::xlen-1:0] imem_rdata,
  output core_pkg::instr_t          if_instr,
  output logic [core_pkg::xlen-1:0] if_pc,
  output logic                      if_valid
);

  // word pc with a carry bit past the last word, and the pc of the read in flight
  logic [aw:0]   pc;
  logic [aw-1:0] pc_d;
  logic          valid_d;

  // while held, keep reading the word in flight so it is
  // still on imem_rdata when the pipeline moves again
  assign imem_addr = hold ? pc_d : pc[aw-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= '0;
      pc_d     <= '0;
      valid_d  <= 1'b0;
      if_valid <= 1'b0;
      if_pc    <= '0;
    end else if (!hold) begin
      pc       <= pc + 1'b1;
      pc_d     <= pc[aw-1:0];
      valid_d  <= 1'b1;
      if_valid <= valid_d;
      // byte address of the word now entering decode
      if_pc    <= {{(core_pkg::xlen - aw - 2){1'b0}}, pc_d, 2'b00};
    end
  end

  // fetch-to-decode payload
  always_ff @(posedge clk) begin
    if (!hold) begin
      if_instr <= imem_rdata;
    end
  end

  pc_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc <= (aw + 1)'(imem_depth - 1)
  );

endmodule

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem #(
  parameter int imem_depth = 64,
  localparam int aw = $clog2(imem_depth)
) (
  input  logic                      clk,
  input  logic                      we,
  input  logic [aw-1:0]             waddr,
  input  logic [core_pkg::xlen-1:0] wdata,
  input  logic [aw-1:0]             raddr,
  output logic [core_pkg::xlen-1:0] rdata
);

  logic [core_pkg::xlen-1:0] mem [imem_depth];

  // host write path
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, shared by fetch and host readback
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== rtl/mini_core.sv ====
`timescale 1ns/1ps

module mini_core #(
  parameter int imem_depth = 64,
  localparam int aw = $clog2(imem_depth)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      prog,
  input  logic                      prog_we,
  input  logic [aw-1:0]             prog_addr,
  input  logic [core_pkg::xlen-1:0] prog_data,
  input  logic                      debug,
  input  logic [4:0]                debug_input,
  output logic [core_pkg::xlen-1:0] debug_output,
  output logic                      halted
);

  logic                      hold;
  logic                      ecall_stall;

  // memory and fetch
  logic [aw-1:0]             imem_addr;
  logic [aw-1:0]             imem_raddr;
  logic [core_pkg::xlen-1:0] imem_rdata;
  core_pkg::instr_t          if_instr;
  logic [core_pkg::xlen-1:0] if_pc;
  logic                      if_valid;

  // register file
  logic [4:0]                rs1;
  logic [4:0]                rs2;
  logic [core_pkg::xlen-1:0] rs1_data;
  logic [core_pkg::xlen-1:0] rs2_data;
  logic [core_pkg::xlen-1:0] dbg_data;

  // decode to execute
  logic [core_pkg::xlen-1:0] dec_pc;
  logic                      ex_valid;
  core_pkg::alu_op_t         ex_alu_op;
  logic [core_pkg::xlen-1:0] ex_a;
  logic [core_pkg::xlen-1:0] ex_b;
  logic [4:0]                ex_rd;
  logic                      ex_regwrite;
  logic                      ex_ecall;

  // writeback
  logic                      wb_we;
  logic [4:0]                wb_rd;
  logic [core_pkg::xlen-1:0] wb_data;

  ////////////////////
  // hold and host muxing
  ////////////////////

  // an ecall in execute freezes its own cycle, halted keeps it frozen
  assign ecall_stall = ex_valid && ex_ecall;
  assign hold = prog || debug || halted || ecall_stall;

  assign imem_raddr = prog ? prog_addr : imem_addr;

  // prog readback wins over register debug
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      debug_output <= '0;
    end else if (prog) begin
      debug_output <= imem_rdata;
    end else if (debug) begin
      debug_output <= (debug_input == 5'd0) ? dec_pc : dbg_data;
    end else begin
      debug_output <= '0;
    end
  end

  ////////////////////
  // pipeline
  ////////////////////

  instr_mem #(
    .imem_depth(imem_depth)
  ) i_instr_mem (
    .clk  (clk),
    .we   (prog && prog_we),
    .waddr(prog_addr),
    .wdata(prog_data),
    .raddr(imem_raddr),
    .rdata(imem_rdata)
  );

  fetch_stage #(
    .imem_depth(imem_depth)
  ) i_fetch_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .hold      (hold),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .if_instr  (if_instr),
    .if_pc     (if_pc),
    .if_valid  (if_valid)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .dbg_addr(debug_input),
    .dbg_data(dbg_data),
    .we      (wb_we),
    .rd      (wb_rd),
    .wd      (wb_data)
  );

  decode_stage i_decode_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .if_instr   (if_instr),
    .if_pc      (if_pc),
    .if_valid   (if_valid),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .fwd_we     (wb_we),
    .fwd_rd     (wb_rd),
    .fwd_data   (wb_data),
    .dec_pc     (dec_pc),
    .ex_valid   (ex_valid),
    .ex_alu_op  (ex_alu_op),
    .ex_a       (ex_a),
    .ex_b       (ex_b),
    .ex_rd      (ex_rd),
    .ex_regwrite(ex_regwrite),
    .ex_ecall   (ex_ecall)
  );

  execute_stage i_execute_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .ex_valid   (ex_valid),
    .ex_alu_op  (ex_alu_op),
    .ex_a       (ex_a),
    .ex_b       (ex_b),
    .ex_rd      (ex_rd),
    .ex_regwrite(ex_regwrite),
    .ex_ecall   (ex_ecall),
    .wb_we      (wb_we),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .halted     (halted)
  );

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [4:0]                rs1,
  input  logic [4:0]                rs2,
  output logic [core_pkg::xlen-1:0] rs1_data,
  output logic [core_pkg::xlen-1:0] rs2_data,
  input  logic [4:0]                dbg_addr,
  output logic [core_pkg::xlen-1:0] dbg_data,
  input  logic                      we,
  input  logic [4:0]                rd,
  input  logic [core_pkg::xlen-1:0] wd
);

  // x0 is cleared at reset and never written
  logic [core_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

  // operand ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // debug port
  assign dbg_data = regs[dbg_addr];

  x0_reads_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    rs1 == 5'd0 |-> rs1_data == '0
  );

endmodule

// ==== sim/core_model.svh ====
`ifndef core_model_svh
`define core_model_svh

// random source, program generator and instruction-level model of the core

logic [31:0] rng_state;
logic [31:0] model_regs [32];
int          model_halt_pc;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

function automatic logic [31:0] next_random();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// mostly low registers so neighbours depend on each other
function automatic logic [4:0] random_reg();
  logic [31:0] r;
  r = next_random();
  return r[31] ? {2'b00, r[2:0]} : r[8:4];
endfunction

function automatic logic [31:0] random_instr();
  core_pkg::instr_t w;
  logic [31:0]      r;
  int               kind;
  kind = next_random() % 11;
  r = next_random();
  w = '0;
  if (kind < 6) begin
    w.r_fmt.opcode = core_pkg::op_reg;
    w.r_fmt.rd = random_reg();
    w.r_fmt.rs1 = random_reg();
    w.r_fmt.rs2 = random_reg();
    w.r_fmt.funct7 = (kind == 1) ? core_pkg::f7_sub : core_pkg::f7_base;
    case (kind)
      0, 1:    w.r_fmt.funct3 = core_pkg::f3_add_sub;
      2:       w.r_fmt.funct3 = core_pkg::f3_and;
      3:       w.r_fmt.funct3 = core_pkg::f3_or;
      4:       w.r_fmt.funct3 = core_pkg::f3_xor;
      default: w.r_fmt.funct3 = core_pkg::f3_slt;
    endcase
  end else if (kind < 10) begin
    w.i_fmt.opcode = core_pkg::op_imm;
    w.i_fmt.rd = random_reg();
    w.i_fmt.rs1 = random_reg();
    w.i_fmt.imm = r[11:0];
    case (kind)
      6:       w.i_fmt.funct3 = core_pkg::f3_add_sub;
      7:       w.i_fmt.funct3 = core_pkg::f3_and;
      8:       w.i_fmt.funct3 = core_pkg::f3_or;
      default: w.i_fmt.funct3 = core_pkg::f3_xor;
    endcase
  end else begin
    w.u_fmt.opcode = core_pkg::op_lui;
    w.u_fmt.rd = random_reg();
    w.u_fmt.imm = r[19:0];
  end
  return w;
endfunction

// executes prog_image in order up to the first ecall
task automatic run_model();
  core_pkg::instr_t w;
  logic [31:0]      a;
  logic [31:0]      b;
  logic [31:0]      simm;
  logic [31:0]      res;
  logic             writes;
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = '0;
  end
  model_halt_pc = 0;
  for (int i = 0; i < imem_depth; i++) begin
    w = prog_image[i];
    if (w == core_pkg::ecall_word) begin
      model_halt_pc = (i + 1) * 4;
      break;
    end
    a = model_regs[w.r_fmt.rs1];
    b = model_regs[w.r_fmt.rs2];
    simm = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
    res = '0;
    writes = 1'b1;
    if (w.r_fmt.opcode == core_pkg::op_reg) begin
      if (w.r_fmt.funct7 == core_pkg::f7_sub && w.r_fmt.funct3 == core_pkg::f3_add_sub) begin
        res = a - b;
      end else if (w.r_fmt.funct7 != core_pkg::f7_base) begin
        writes = 1'b0;
      end else if (w.r_fmt.funct3 == core_pkg::f3_add_sub) begin
        res = a + b;
      end else if (w.r_fmt.funct3 == core_pkg::f3_and) begin
        res = a & b;
      end else if (w.r_fmt.funct3 == core_pkg::f3_or) begin
        res = a | b;
      end else if (w.r_fmt.funct3 == core_pkg::f3_xor) begin
        res = a ^ b;
      end else if (w.r_fmt.funct3 == core_pkg::f3_slt) begin
        res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      end else begin
        writes = 1'b0;
      end
    end else if (w.i_fmt.opcode == core_pkg::op_imm) begin
      if (w.i_fmt.funct3 == core_pkg::f3_add_sub) begin
        res = a + simm;
      end else if (w.i_fmt.funct3 == core_pkg::f3_and) begin
        res = a & simm;
      end else if (w.i_fmt.funct3 == core_pkg::f3_or) begin
        res = a | simm;
      end else if (w.i_fmt.funct3 == core_pkg::f3_xor) begin
        res = a ^ simm;
      end else begin
        writes = 1'b0;
      end
    end else if (w.u_fmt.opcode == core_pkg::op_lui) begin
      res = {w.u_fmt.imm, 12'h000};
    end else begin
      writes = 1'b0;
    end
    if (writes && w.r_fmt.rd != 5'd0) begin
      model_regs[w.r_fmt.rd] = res;
    end
  end
endtask

`endif

// ==== sim/tb_mini_core.sv ====
`timescale 1ns/1ps

module tb_mini_core;

  localparam int imem_depth = 64;
  localparam int aw = $clog2(imem_depth);
  localparam int prog_len = 40;
  localparam int reset_cycles = 5;
  // execution budget, then loading, readback and register reads of both runs
  localparam int watchdog_ns = imem_depth * 200 + 2 * (imem_depth * 5 + 100) * 20;

  logic        clk;
  logic        rst_n;
  logic        prog;
  logic        prog_we;
  logic [aw-1:0] prog_addr;
  logic [31:0] prog_data;
  logic        debug;
  logic [4:0]  debug_input;
  logic [31:0] debug_output;
  logic        halted;

  logic [31:0] prog_image [imem_depth];
  int          mismatches;
  int          other_errors;
  logic        waiting_halt;

  `include "core_model.svh"

  mini_core #(
    .imem_depth(imem_depth)
  ) i_mini_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .prog        (prog),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .debug       (debug),
    .debug_input (debug_input),
    .debug_output(debug_output),
    .halted      (halted)
  );

  always #10 clk = ~clk;

  ////////////////////
  // stimulus helpers
  ////////////////////

  // random body, ecall, writers the core must never retire, then random words
  task automatic build_program();
    for (int i = 0; i < imem_depth; i++) begin
      if (i < prog_len) begin
        prog_image[i] = random_instr();
      end else if (i == prog_len) begin
        prog_image[i] = core_pkg::ecall_word;
      end else if (i <= prog_len + 2) begin
        prog_image[i] = random_instr();
      end else begin
        prog_image[i] = next_random();
      end
    end
  endtask

  // prog goes high on release so the pipeline stays frozen until loaded
  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    prog <= 1'b1;
    prog_we <= 1'b0;
    @(negedge clk);
    if (debug_output !== 32'd0 || halted !== 1'b0) begin
      mismatches++;
      $display("mismatch at %0t: after reset debug_output %h halted %b, expected 0 and 0",
               $time, debug_output, halted);
    end
  endtask

  task automatic load_program();
    for (int a = 0; a < imem_depth; a++) begin
      @(posedge clk);
      prog <= 1'b1;
      prog_we <= 1'b1;
      prog_addr <= a[aw-1:0];
      prog_data <= prog_image[a];
    end
  endtask

  // two-cycle readback latency through debug_output
  task automatic check_readback();
    for (int a = 0; a < imem_depth; a++) begin
      @(posedge clk);
      prog_we <= 1'b0;
      prog_addr <= a[aw-1:0];
      @(posedge clk);
      @(posedge clk);
      @(negedge clk);
      if (debug_output !== prog_image[a]) begin
        mismatches++;
        $display("mismatch at %0t: imem[%0d] reads %h, expected %h",
                 $time, a, debug_output, prog_image[a]);
      end
    end
  endtask

  task automatic run_until_halt(input logic pulse_debug);
    int          stretch;
    logic [31:0] r;
    stretch = 0;
    waiting_halt = 1'b1;
    @(posedge clk);
    prog <= 1'b0;
    @(negedge clk);
    while (halted !== 1'b1) begin
      @(posedge clk);
      if (pulse_debug) begin
        r = next_random();
        if (stretch > 0) begin
          stretch = stretch - 1;
        end else if (debug) begin
          debug <= 1'b0;
        end else if (r[1:0] == 2'b00) begin
          debug <= 1'b1;
          debug_input <= r[12:8];
          stretch = r[18:16];
        end
      end
      @(negedge clk);
    end
    waiting_halt = 1'b0;
  endtask

  task automatic check_registers(input string tag);
    for (int r = 1; r < 32; r++) begin
      @(posedge clk);
      debug <= 1'b1;
      debug_input <= r[4:0];
      @(posedge clk);
      @(negedge clk);
      if (debug_output !== model_regs[r]) begin
        mismatches++;
        $display("mismatch at %0t: %s x%0d is %h, expected %h",
                 $time, tag, r, debug_output, model_regs[r]);
      end
    end
    // index 0 shows the decode pc, the word after the ecall
    @(posedge clk);
    debug_input <= 5'd0;
    @(posedge clk);
    @(negedge clk);
    if (debug_output !== model_halt_pc) begin
      mismatches++;
      $display("mismatch at %0t: %s decode pc is %h, expected %h",
               $time, tag, debug_output, model_halt_pc);
    end
    @(posedge clk);
    debug <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    if (debug_output !== 32'd0) begin
      mismatches++;
      $display("mismatch at %0t: %s idle debug_output is %h, expected 0",
               $time, tag, debug_output);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    prog = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    debug = 1'b0;
    debug_input = '0;
    mismatches = 0;
    other_errors = 0;
    waiting_halt = 1'b0;
    rng_state = 32'h451e_2285;

    // first run, nothing disturbs execution
    build_program();
    run_model();
    apply_reset();
    load_program();
    check_readback();
    run_until_halt(1'b0);
    check_registers("run 1");

    // second run with random debug stretches
    build_program();
    run_model();
    apply_reset();
    load_program();
    check_readback();
    run_until_halt(1'b1);
    check_registers("run 2");

    $display("%0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    other_errors++;
    if (waiting_halt) begin
      $display("error at %0t: the core never halted", $time);
    end else begin
      $display("error at %0t: the run took too long and was stopped", $time);
    end
    $display("%0d mismatches, %0d other errors", mismatches, other_errors);
    $display("sim failed");
    $finish;
  end

endmodule
